//--- files.f
+incdir+verilog
verilog/ttc_reg_pkg.sv
verilog/ttc_cnt_pkg.sv
verilog/ttc_apb_regs.sv
verilog/ttc_timer_counter.sv
verilog/ttc_top.sv
sim/ttc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the timer-counter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module ttc_tb \
   -o ttc_sim

./obj_dir/ttc_sim | tee sim.log

# Pass only if the testbench printed its pass line
if grep -qx "TEST OK" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- sim/ttc_tb.sv
//----------------------------
// Testbench for the triple timer-counter
// Table-driven APB stimulus with register and IRQ checks
//----------------------------
`include "ttc_params.svh"
`default_nettype none

module ttc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {
      K_WRITE,    // APB write
      K_READ,     // APB read and compare
      K_WAIT,     // Idle clock cycles, count in data
      K_IRQ       // Compare interrupt port
   } kind_e;

   typedef struct packed {
      kind_e             kind;
      logic [1:0]        timer;
      ttc_reg_pkg::reg_e reg_id;
      logic [31:0]       data;
      logic [31:0]       exp;
      logic [31:0]       mask;   // Bits that take part in the compare
   } step_t;

   logic                        pclk;
   logic                        rst;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   logic [7:0]                  paddr;
   logic [31:0]                 pwdata;
   logic [31:0]                 prdata;
   logic [`TTC_NUM_TIMERS-1:0]  interrupt;

   step_t       steps[$];
   int          n_checks;
   int          n_fail;
   logic [31:0] lfsr_state;
   logic [31:0] t1_interval;   // Random interval kept for the isolation check

   ttc_top UUT (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   always #20 pclk = ~pclk;   // 40 ns period

   //----------------------------
   // Helpers
   //----------------------------
   // x^32 + x^22 + x^2 + x + 1, one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // Implemented width of each writable register
   function automatic logic [31:0] width_mask(input ttc_reg_pkg::reg_e reg_id);
      case (reg_id)
         ttc_reg_pkg::REG_CLK_CTRL:  return (32'd1 << `TTC_PRESC_W) - 32'd1;
         ttc_reg_pkg::REG_CNTR_CTRL: return 32'h1F;
         ttc_reg_pkg::REG_IRQ_EN:    return 32'hF;
         default:                    return (32'd1 << `TTC_CNT_W) - 32'd1;
      endcase
   endfunction

   function automatic logic [7:0] addr_of(input logic [1:0] timer,
                                          input ttc_reg_pkg::reg_e reg_id);
      return 8'(int'(timer) * `TTC_TIMER_SPACING + int'(reg_id) * 4);
   endfunction

   task automatic add_step(input kind_e kind, input int timer,
                           input ttc_reg_pkg::reg_e reg_id,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic [31:0] mask);
      step_t s;
      s.kind   = kind;
      s.timer  = 2'(timer);
      s.reg_id = reg_id;
      s.data   = data;
      s.exp    = exp;
      s.mask   = mask;
      steps.push_back(s);
   endtask

   task automatic add_write(input int timer, input ttc_reg_pkg::reg_e reg_id,
                            input logic [31:0] data);
      add_step(K_WRITE, timer, reg_id, data, '0, '0);
   endtask

   task automatic add_read(input int timer, input ttc_reg_pkg::reg_e reg_id,
                           input logic [31:0] exp, input logic [31:0] mask);
      add_step(K_READ, timer, reg_id, '0, exp, mask);
   endtask

   task automatic add_wait(input int cycles);
      add_step(K_WAIT, 0, ttc_reg_pkg::REG_CLK_CTRL, 32'(cycles), '0, '0);
   endtask

   task automatic add_irq_check(input logic [31:0] exp);
      add_step(K_IRQ, 0, ttc_reg_pkg::REG_CLK_CTRL, '0, exp, '1);
   endtask

   //----------------------------
   // Stimulus table
   //----------------------------
   task automatic build_table();
      logic [31:0]       d;
      ttc_reg_pkg::reg_e rw_regs [7];
      rw_regs = '{ttc_reg_pkg::REG_CLK_CTRL, ttc_reg_pkg::REG_CNTR_CTRL,
                  ttc_reg_pkg::REG_INTERVAL, ttc_reg_pkg::REG_MATCH1,
                  ttc_reg_pkg::REG_MATCH2, ttc_reg_pkg::REG_MATCH3,
                  ttc_reg_pkg::REG_IRQ_EN};
      // Reset values, all timers, all offsets
      for (int t = 0; t < `TTC_NUM_TIMERS; t++)
         for (int r = 0; r <= int'(ttc_reg_pkg::REG_IRQ_EN); r++)
            add_read(t, ttc_reg_pkg::reg_e'(4'(r)), '0, '1);
      add_irq_check(0);
      // Random readback on timer 1
      foreach (rw_regs[i]) begin
         d = lfsr_bits(32);
         if (rw_regs[i] == ttc_reg_pkg::REG_CNTR_CTRL)
            d = d & ~32'h11;   // Stays stopped, no counter reset
         if (rw_regs[i] == ttc_reg_pkg::REG_INTERVAL)
            t1_interval = d & width_mask(rw_regs[i]);
         add_write(1, rw_regs[i], d);
         add_read(1, rw_regs[i], d & width_mask(rw_regs[i]), '1);
      end
      // Hold and reset, p=0: one tick per cycle for 8 edges
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h01);
      add_wait(5);
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h00);
      add_read(0, ttc_reg_pkg::REG_COUNTER, 32'd8, '1);
      add_read(0, ttc_reg_pkg::REG_COUNTER, 32'd8, '1);   // Held while disabled
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h10);
      add_read(0, ttc_reg_pkg::REG_COUNTER, '0, '1);
      add_read(0, ttc_reg_pkg::REG_CNTR_CTRL, '0, '1);    // Reset bit not stored
      // Up interval, interval 5, p=1: 16 ticks end at 16 mod 6
      add_write(0, ttc_reg_pkg::REG_CLK_CTRL, 32'h1);
      add_write(0, ttc_reg_pkg::REG_INTERVAL, 32'd5);
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h03);
      add_wait(30);
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h02);
      add_read(0, ttc_reg_pkg::REG_IRQ, 32'h1, '1);
      add_read(0, ttc_reg_pkg::REG_COUNTER, 32'd4, '1);
      // Match 1 at count 3, masked off
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h12);
      add_write(0, ttc_reg_pkg::REG_MATCH1, 32'd3);
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h0B);
      add_wait(6);
      add_write(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h0A);   // Stops at 4
      add_irq_check(0);
      add_write(0, ttc_reg_pkg::REG_IRQ_EN, 32'h2);
      add_irq_check(32'b001);
      // Clear on read
      add_read(0, ttc_reg_pkg::REG_IRQ, 32'h2, '1);
      add_read(0, ttc_reg_pkg::REG_IRQ, 32'h0, '1);
      add_irq_check(0);
      // Timer 2 down in interval mode, p=0
      add_write(2, ttc_reg_pkg::REG_INTERVAL, 32'd7);
      add_write(2, ttc_reg_pkg::REG_IRQ_EN, 32'h1);
      add_write(2, ttc_reg_pkg::REG_CNTR_CTRL, 32'h07);
      add_wait(20);
      add_irq_check(32'b100);
      add_read(2, ttc_reg_pkg::REG_COUNTER, '0, 32'hFFFF_FFF8);   // Never above 7
      add_write(2, ttc_reg_pkg::REG_CNTR_CTRL, 32'h06);
      add_read(2, ttc_reg_pkg::REG_IRQ, 32'h1, 32'h1);
      add_irq_check(0);
      // Other timers untouched
      add_read(0, ttc_reg_pkg::REG_COUNTER, 32'd4, '1);
      add_read(0, ttc_reg_pkg::REG_CNTR_CTRL, 32'h0A, '1);
      add_read(1, ttc_reg_pkg::REG_COUNTER, '0, '1);
      add_read(1, ttc_reg_pkg::REG_INTERVAL, t1_interval, '1);
   endtask

   //----------------------------
   // APB transfers and checks
   //----------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge pclk);   // Setup
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);   // Access
      penable <= 1'b1;
      @(posedge pclk);   // Write lands here
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;
      @(negedge pclk);   // Mid access cycle
      data = prdata;
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_data(input ttc_reg_pkg::reg_e reg_id, input int timer,
                             input logic [31:0] exp, input logic [31:0] mask,
                             input logic [31:0] act);
      n_checks++;
      if ((act & mask) !== (exp & mask)) begin
         n_fail++;
         $display("[FAIL] %0t ns prdata (timer %0d %s): expected %h, got %h, mask %h",
                  $time, timer, reg_id.name(), exp, act, mask);
      end else begin
         $display("[PASS] %0t ns prdata (timer %0d %s) = %h",
                  $time, timer, reg_id.name(), act);
      end
   endtask

   task automatic check_irq(input logic [`TTC_NUM_TIMERS-1:0] exp,
                            input logic [`TTC_NUM_TIMERS-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_fail++;
         $display("[FAIL] %0t ns interrupt: expected %b, got %b", $time, exp, act);
      end else begin
         $display("[PASS] %0t ns interrupt = %b", $time, act);
      end
   endtask

   task automatic run_step(input step_t s);
      logic [31:0] rd;
      case (s.kind)
         K_WRITE: apb_write(addr_of(s.timer, s.reg_id), s.data);
         K_READ: begin
            apb_read(addr_of(s.timer, s.reg_id), rd);
            check_data(s.reg_id, int'(s.timer), s.exp, s.mask, rd);
         end
         K_WAIT: repeat (s.data) @(posedge pclk);
         default: begin
            @(negedge pclk);   // Interrupt is combinational, settled here
            check_irq(s.exp[`TTC_NUM_TIMERS-1:0], interrupt);
         end
      endcase
   endtask

   //----------------------------
   // Main sequence and watchdog
   //----------------------------
   initial begin
      pclk       = 1'b0;
      rst        = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      n_checks   = 0;
      n_fail     = 0;
      lfsr_state = 32'h1721;
      build_table();
      repeat (10) @(posedge pclk);
      rst <= 1'b0;
      foreach (steps[i])
         run_step(steps[i]);
      repeat (2) @(posedge pclk);
      $display("Checks run: %0d, failed: %0d", n_checks, n_fail);
      if (n_fail == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial begin
      longint timeout_ns;
      #1;   // Table built at time 0
      timeout_ns = (longint'(steps.size()) * 64 + 10) * 40;
      #(timeout_ns);
      $display("Timeout: the test sequence did not complete in %0d ns", timeout_ns);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/ttc_top.sv
//-----------------------------
// Triple timer-counter top level
// APB decoder and three timer blocks
//-----------------------------
`include "ttc_params.svh"
`default_nettype none

module ttc_top (
   input  wire                        pclk,
   input  wire                        rst,
   input  wire                        psel,
   input  wire                        penable,
   input  wire                        pwrite,
   input  wire [7:0]                  paddr,
   input  wire [31:0]                 pwdata,
   output wire [31:0]                 prdata,
   output wire [`TTC_NUM_TIMERS-1:0]  interrupt   // Bit n from timer n
);

   // Per-timer register contents back to the read mux
   wire ttc_reg_pkg::clk_ctrl_t  clk_ctrl    [`TTC_NUM_TIMERS];
   wire ttc_reg_pkg::cntr_ctrl_t cntr_ctrl   [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::cnt_t       counter_val [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::cnt_t       interval    [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::cnt_t       match1      [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::cnt_t       match2      [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::cnt_t       match3      [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::irq_t       irq         [`TTC_NUM_TIMERS];
   wire ttc_cnt_pkg::irq_t       irq_en      [`TTC_NUM_TIMERS];
   wire ttc_reg_pkg::reg_sel_t   reg_sel     [`TTC_NUM_TIMERS];   // Decoder to timers
   wire [`TTC_NUM_TIMERS-1:0]    clear_irq;

   ttc_apb_regs i_apb_regs (
      .pclk (pclk), .rst (rst),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
      .clk_ctrl (clk_ctrl), .cntr_ctrl (cntr_ctrl), .counter_val (counter_val),
      .interval (interval), .match1 (match1), .match2 (match2), .match3 (match3),
      .irq (irq), .irq_en (irq_en),
      .prdata (prdata), .reg_sel (reg_sel), .clear_irq (clear_irq)
   );

   ttc_timer_counter i_timer_0 (
      .pclk (pclk), .rst (rst), .wdata (pwdata[`TTC_CNT_W-1:0]),
      .reg_sel (reg_sel[0]), .clear_irq (clear_irq[0]),
      .clk_ctrl (clk_ctrl[0]), .cntr_ctrl (cntr_ctrl[0]), .counter_val (counter_val[0]),
      .interval (interval[0]), .match1 (match1[0]), .match2 (match2[0]), .match3 (match3[0]),
      .irq (irq[0]), .irq_en (irq_en[0]), .interrupt (interrupt[0])
   );

   ttc_timer_counter i_timer_1 (
      .pclk (pclk), .rst (rst), .wdata (pwdata[`TTC_CNT_W-1:0]),
      .reg_sel (reg_sel[1]), .clear_irq (clear_irq[1]),
      .clk_ctrl (clk_ctrl[1]), .cntr_ctrl (cntr_ctrl[1]), .counter_val (counter_val[1]),
      .interval (interval[1]), .match1 (match1[1]), .match2 (match2[1]), .match3 (match3[1]),
      .irq (irq[1]), .irq_en (irq_en[1]), .interrupt (interrupt[1])
   );

   ttc_timer_counter i_timer_2 (
      .pclk (pclk), .rst (rst), .wdata (pwdata[`TTC_CNT_W-1:0]),
      .reg_sel (reg_sel[2]), .clear_irq (clear_irq[2]),
      .clk_ctrl (clk_ctrl[2]), .cntr_ctrl (cntr_ctrl[2]), .counter_val (counter_val[2]),
      .interval (interval[2]), .match1 (match1[2]), .match2 (match2[2]), .match3 (match3[2]),
      .irq (irq[2]), .irq_en (irq_en[2]), .interrupt (interrupt[2])
   );

endmodule

`default_nettype wire

//--- verilog/ttc_timer_counter.sv
//-----------------------------
// One timer-counter block
// Prescaler, up/down counter, match and IRQ
//-----------------------------
`include "ttc_params.svh"
`default_nettype none

module ttc_timer_counter (
   input  wire                          pclk,
   input  wire                          rst,
   input  wire [`TTC_CNT_W-1:0]         wdata,       // Low half of pwdata
   input  wire ttc_reg_pkg::reg_sel_t   reg_sel,     // Write access selects
   input  wire                          clear_irq,   // IRQ register being read
   output ttc_reg_pkg::clk_ctrl_t       clk_ctrl,
   output ttc_reg_pkg::cntr_ctrl_t      cntr_ctrl,
   output ttc_cnt_pkg::cnt_t            counter_val,
   output ttc_cnt_pkg::cnt_t            interval,
   output ttc_cnt_pkg::cnt_t            match1,
   output ttc_cnt_pkg::cnt_t            match2,
   output ttc_cnt_pkg::cnt_t            match3,
   output ttc_cnt_pkg::irq_t            irq,         // Sticky events
   output ttc_cnt_pkg::irq_t            irq_en,
   output logic                         interrupt
);

   logic [ttc_reg_pkg::CNTR_RST_BIT-1:0] ctrl_q;   // Reset bit never stored
   logic [`TTC_PRESC_W-1:0]              presc_cnt;
   logic                                 cnt_en;
   logic                                 match_en;
   logic                                 ctrl_wr;
   logic                                 cnt_rst_wr;
   logic                                 tick;
   logic                                 wrap;
   ttc_cnt_pkg::cnt_mode_e               cnt_mode;
   ttc_cnt_pkg::cnt_dir_e                cnt_dir;
   ttc_cnt_pkg::cnt_t                    cnt_next;
   ttc_cnt_pkg::irq_t                    evt;

   //-----------------------------
   // Control registers
   //-----------------------------
   always_ff @(posedge pclk) begin
      if (rst) begin
         clk_ctrl <= '0;
         ctrl_q   <= '0;
         interval <= '0;
         match1   <= '0;
         match2   <= '0;
         match3   <= '0;
         irq_en   <= '0;
      end else begin
         if (reg_sel[ttc_reg_pkg::REG_CLK_CTRL])
            clk_ctrl <= wdata[`TTC_PRESC_W-1:0];
         if (ctrl_wr)
            ctrl_q <= wdata[ttc_reg_pkg::CNTR_RST_BIT-1:0];
         if (reg_sel[ttc_reg_pkg::REG_INTERVAL])
            interval <= wdata;
         if (reg_sel[ttc_reg_pkg::REG_MATCH1])
            match1 <= wdata;
         if (reg_sel[ttc_reg_pkg::REG_MATCH2])
            match2 <= wdata;
         if (reg_sel[ttc_reg_pkg::REG_MATCH3])
            match3 <= wdata;
         if (reg_sel[ttc_reg_pkg::REG_IRQ_EN])
            irq_en <= wdata[ttc_cnt_pkg::IRQ_NUM-1:0];
      end
   end

   assign cntr_ctrl  = {1'b0, ctrl_q};   // Reset bit reads back 0
   assign ctrl_wr    = reg_sel[ttc_reg_pkg::REG_CNTR_CTRL];
   assign cnt_rst_wr = ctrl_wr && wdata[ttc_reg_pkg::CNTR_RST_BIT];

   assign cnt_en   = ctrl_q[ttc_reg_pkg::CNTR_EN_BIT];
   assign match_en = ctrl_q[ttc_reg_pkg::CNTR_MATCH_EN_BIT];
   assign cnt_mode = ttc_cnt_pkg::cnt_mode_e'(ctrl_q[ttc_reg_pkg::CNTR_MODE_BIT]);
   assign cnt_dir  = ttc_cnt_pkg::cnt_dir_e'(ctrl_q[ttc_reg_pkg::CNTR_DIR_BIT]);

   //-----------------------------
   // Prescaler
   //-----------------------------
   // Tick every p+1 cycles, >= covers p lowered mid count
   assign tick = cnt_en && (presc_cnt >= clk_ctrl);

   always_ff @(posedge pclk) begin
      if (rst)
         presc_cnt <= '0;
      else if (ctrl_wr || tick || !cnt_en)
         presc_cnt <= '0;   // Restart on control write
      else
         presc_cnt <= presc_cnt + 1'b1;
   end

   //-----------------------------
   // Counter
   //-----------------------------
   always_comb begin
      cnt_next = counter_val + 1'b1;
      wrap     = 1'b0;
      if (cnt_dir == ttc_cnt_pkg::DIR_UP) begin
         if (cnt_mode == ttc_cnt_pkg::MODE_INTERVAL && counter_val >= interval) begin
            cnt_next = '0;   // Back to 0 at interval
            wrap     = 1'b1;
         end else if (counter_val == '1) begin
            wrap = 1'b1;   // Natural rollover
         end
      end else begin
         cnt_next = counter_val - 1'b1;
         if (counter_val == '0) begin
            cnt_next = (cnt_mode == ttc_cnt_pkg::MODE_INTERVAL) ? interval : '1;
            wrap     = 1'b1;
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (rst)
         counter_val <= '0;
      else if (cnt_rst_wr)
         counter_val <= '0;   // Software counter reset wins
      else if (tick)
         counter_val <= cnt_next;
   end

   //-----------------------------
   // Events and interrupt
   //-----------------------------
   always_comb begin
      evt = '0;
      evt[ttc_cnt_pkg::IRQ_WRAP]   = tick && wrap;
      evt[ttc_cnt_pkg::IRQ_MATCH1] = tick && match_en && (cnt_next == match1);
      evt[ttc_cnt_pkg::IRQ_MATCH2] = tick && match_en && (cnt_next == match2);
      evt[ttc_cnt_pkg::IRQ_MATCH3] = tick && match_en && (cnt_next == match3);
   end

   always_ff @(posedge pclk) begin
      if (rst)
         irq <= '0;
      else if (clear_irq)
         irq <= evt;   // Event in the read cycle survives the clear
      else
         irq <= irq | evt;
   end

   assign interrupt = |(irq & irq_en);   // No clock delay

   // Up interval count stays within interval after a tick
   a_interval_bound: assert property (@(posedge pclk) disable iff (rst)
      (tick && cnt_dir == ttc_cnt_pkg::DIR_UP &&
       cnt_mode == ttc_cnt_pkg::MODE_INTERVAL &&
       !reg_sel[ttc_reg_pkg::REG_INTERVAL]) |=> (counter_val <= interval));

   // Quiet line stays quiet without a new event or mask write
   a_irq_quiet: assert property (@(posedge pclk) disable iff (rst)
      (((irq & irq_en) == '0) && (evt == '0) &&
       !reg_sel[ttc_reg_pkg::REG_IRQ_EN]) |=> !interrupt);

endmodule

`default_nettype wire

//--- verilog/ttc_apb_regs.sv
//-----------------------------
// APB decoder for the triple timer-counter
// Write selects, clear-on-read pulses, read mux
//-----------------------------
`include "ttc_params.svh"
`default_nettype none

module ttc_apb_regs (
   input  wire                          pclk,
   input  wire                          rst,
   input  wire                          psel,
   input  wire                          penable,
   input  wire                          pwrite,
   input  wire [7:0]                    paddr,
   input  wire ttc_reg_pkg::clk_ctrl_t  clk_ctrl    [`TTC_NUM_TIMERS],
   input  wire ttc_reg_pkg::cntr_ctrl_t cntr_ctrl   [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::cnt_t       counter_val [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::cnt_t       interval    [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::cnt_t       match1      [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::cnt_t       match2      [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::cnt_t       match3      [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::irq_t       irq         [`TTC_NUM_TIMERS],
   input  wire ttc_cnt_pkg::irq_t       irq_en      [`TTC_NUM_TIMERS],
   output logic [31:0]                  prdata,      // Valid in access cycle
   output ttc_reg_pkg::reg_sel_t        reg_sel     [`TTC_NUM_TIMERS],
   output logic [`TTC_NUM_TIMERS-1:0]   clear_irq    // IRQ read access
);

   localparam int TIMER_LSB = $clog2(`TTC_TIMER_SPACING);   // 6 for a 0x40 stride

   logic [7-TIMER_LSB:0] timer_idx;
   ttc_reg_pkg::reg_e    reg_idx;
   logic                 addr_hit;
   logic                 wr_acc;
   logic                 rd_acc;
   logic                 rd_setup;
   logic [31:0]          rd_mux;
   logic [`TTC_NUM_TIMERS*ttc_reg_pkg::REG_NUM-1:0] all_sel;   // Flat view of selects

   //-----------------------------
   // Address and phase decode
   //-----------------------------
   assign timer_idx = paddr[7:TIMER_LSB];
   assign reg_idx   = ttc_reg_pkg::reg_e'(paddr[TIMER_LSB-1:2]);
   assign addr_hit  = (int'(timer_idx) < `TTC_NUM_TIMERS) &&
                      (reg_idx <= ttc_reg_pkg::REG_IRQ_EN);   // Offsets 9..15 unmapped

   assign wr_acc   = psel && penable && pwrite;
   assign rd_acc   = psel && penable && !pwrite;
   assign rd_setup = psel && !penable && !pwrite;   // Read data sampled here

   // One select per write access, combinational from the bus
   always_comb begin
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         reg_sel[t]   = '0;
         clear_irq[t] = 1'b0;
         if (addr_hit && int'(timer_idx) == t) begin
            reg_sel[t][reg_idx] = wr_acc;   // Timer ignores read-only slots
            clear_irq[t]        = rd_acc && (reg_idx == ttc_reg_pkg::REG_IRQ);
         end
      end
   end

   //-----------------------------
   // Read mux
   //-----------------------------
   always_comb begin
      rd_mux = '0;   // Unmapped reads return 0
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         if (addr_hit && int'(timer_idx) == t) begin
            case (reg_idx)
               ttc_reg_pkg::REG_CLK_CTRL:  rd_mux = 32'(clk_ctrl[t]);
               ttc_reg_pkg::REG_CNTR_CTRL: rd_mux = 32'(cntr_ctrl[t]);
               ttc_reg_pkg::REG_COUNTER:   rd_mux = 32'(counter_val[t]);
               ttc_reg_pkg::REG_INTERVAL:  rd_mux = 32'(interval[t]);
               ttc_reg_pkg::REG_MATCH1:    rd_mux = 32'(match1[t]);
               ttc_reg_pkg::REG_MATCH2:    rd_mux = 32'(match2[t]);
               ttc_reg_pkg::REG_MATCH3:    rd_mux = 32'(match3[t]);
               ttc_reg_pkg::REG_IRQ:       rd_mux = 32'(irq[t]);
               ttc_reg_pkg::REG_IRQ_EN:    rd_mux = 32'(irq_en[t]);
               default:                    rd_mux = '0;
            endcase
         end
      end
   end

   // Counter captured at end of setup, held through the access cycle
   always_ff @(posedge pclk) begin
      if (rst)
         prdata <= '0;
      else if (rd_setup)
         prdata <= rd_mux;
   end

   //-----------------------------
   // Checks
   //-----------------------------
   always_comb begin
      for (int t = 0; t < `TTC_NUM_TIMERS; t++)
         all_sel[t*ttc_reg_pkg::REG_NUM +: ttc_reg_pkg::REG_NUM] = reg_sel[t];
   end

   // No two timers or registers written in the same cycle
   a_one_sel: assert property (@(posedge pclk) disable iff (rst)
      $onehot0(all_sel));

   // Master protocol check
   a_penable_psel: assert property (@(posedge pclk) disable iff (rst)
      penable |-> psel);

endmodule

`default_nettype wire

//--- verilog/ttc_cnt_pkg.sv
//-----------------------------
// Counter behaviour types
// Modes, direction and interrupt bits
//-----------------------------
`include "ttc_params.svh"
`default_nettype none

package ttc_cnt_pkg;

   typedef enum logic {
      MODE_OVERFLOW = 1'b0,   // Full 16-bit range
      MODE_INTERVAL = 1'b1    // Range bounded by interval
   } cnt_mode_e;

   typedef enum logic {
      DIR_UP   = 1'b0,
      DIR_DOWN = 1'b1
   } cnt_dir_e;

   // Interrupt register bit positions
   typedef enum logic [1:0] {
      IRQ_WRAP   = 2'd0,
      IRQ_MATCH1 = 2'd1,
      IRQ_MATCH2 = 2'd2,
      IRQ_MATCH3 = 2'd3
   } irq_bit_e;

   localparam int IRQ_NUM = 4;
   typedef logic [IRQ_NUM-1:0]    irq_t;   // Indexed by irq_bit_e
   typedef logic [`TTC_CNT_W-1:0] cnt_t;   // Counter, interval, match

endpackage

`default_nettype wire

//--- verilog/ttc_reg_pkg.sv
//-----------------------------
// Register map of one timer-counter block
//-----------------------------
`include "ttc_params.svh"
`default_nettype none

package ttc_reg_pkg;

   // Word offsets inside a timer block
   typedef enum logic [3:0] {
      REG_CLK_CTRL  = 4'd0,
      REG_CNTR_CTRL = 4'd1,
      REG_COUNTER   = 4'd2,   // Read only
      REG_INTERVAL  = 4'd3,
      REG_MATCH1    = 4'd4,
      REG_MATCH2    = 4'd5,
      REG_MATCH3    = 4'd6,
      REG_IRQ       = 4'd7,   // Read only, clears on read
      REG_IRQ_EN    = 4'd8
   } reg_e;

   localparam int REG_NUM = 9;
   typedef logic [REG_NUM-1:0] reg_sel_t;   // One-hot, indexed by reg_e

   // Counter control bit positions
   localparam int CNTR_EN_BIT       = 0;
   localparam int CNTR_MODE_BIT     = 1;
   localparam int CNTR_DIR_BIT      = 2;
   localparam int CNTR_MATCH_EN_BIT = 3;
   localparam int CNTR_RST_BIT      = 4;    // Self clearing
   localparam int CNTR_CTRL_W       = 5;

   typedef logic [CNTR_CTRL_W-1:0]  cntr_ctrl_t;
   typedef logic [`TTC_PRESC_W-1:0] clk_ctrl_t;   // Prescale value p

endpackage

`default_nettype wire

//--- verilog/ttc_params.svh
//-----------------------------
// Triple timer-counter build constants
// Widths, timer count and address stride
//-----------------------------
`ifndef TTC_PARAMS_SVH
`define TTC_PARAMS_SVH

// Counter, interval and match register width
`define TTC_CNT_W          16

// Timer blocks on the bus
`define TTC_NUM_TIMERS     3

// Prescale value width in clock control
`define TTC_PRESC_W        4

// Byte stride between timer blocks
// paddr[7:6] picks the timer, paddr[5:2] the register
`define TTC_TIMER_SPACING  'h40

`endif
